// ==== include/inv_aes_cfg.svh ====
`ifndef INV_AES_CFG_SVH
`define INV_AES_CFG_SVH

// AES-128 geometry
`define AES_BLOCK_BITS 128
`define AES_WORD_BITS 32
`define AES_ROUNDS 10
`define AES_KEY_WORDS 4
`define AES_SCHED_WORDS 44

// Edges from Run sampled in WAIT to Ready
`define AES_LATENCY 52

`endif

// ==== verilog/inv_aes_pkg.sv ====
`default_nettype none

package inv_aes_pkg;

	`include "inv_aes_cfg.svh"

	typedef logic [7:0] aes_byte_t;
	typedef logic [`AES_WORD_BITS-1:0] aes_word_t;

	// Byte 0 and column 0 sit in the top bits
	typedef union packed {
		aes_byte_t [0:`AES_BLOCK_BITS/8-1] bytes;
		aes_word_t [0:`AES_BLOCK_BITS/`AES_WORD_BITS-1] cols;
	} aes_block_u;

	typedef enum logic [2:0] {
		WAIT,
		EXPAND,
		KEY_ADD,
		ROUND,
		FINISH
	} ctrl_state_t;

	function automatic aes_byte_t xtime(aes_byte_t a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
		aes_byte_t acc;
		aes_byte_t m;
		acc = '0;
		m = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				acc = acc ^ m;
			m = xtime(m);
		end
		return acc;
	endfunction

	// a^254 which maps zero to zero
	function automatic aes_byte_t gf_inv(aes_byte_t a);
		aes_byte_t r;
		aes_byte_t p;
		r = 8'h01;
		p = a;
		for (int i = 1; i < 8; i++) begin
			p = gf_mul(p, p);
			r = gf_mul(r, p);
		end
		return r;
	endfunction

	function automatic aes_byte_t rotl8(aes_byte_t a, int n);
		return aes_byte_t'((a << n) | (a >> (8 - n)));
	endfunction

	function automatic aes_byte_t sbox(aes_byte_t a);
		aes_byte_t b;
		b = gf_inv(a);
		return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
	endfunction

	// Undo the affine map, then invert
	function automatic aes_byte_t inv_sbox(aes_byte_t a);
		return gf_inv(rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05);
	endfunction

endpackage

`default_nettype wire

// ==== verilog/key_expansion.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "inv_aes_cfg.svh"

module key_expansion import inv_aes_pkg::*; (
	input logic clk,
	input logic Reset,
	input logic expand_start,
	input aes_block_u Cipherkey,
	input logic [3:0] round_idx,
	output aes_block_u round_key,
	output logic key_ready
);

	aes_word_t sched [0:`AES_SCHED_WORDS-1];
	logic [5:0] word_cnt;
	logic busy;
	aes_byte_t rcon;
	aes_word_t prev_word;
	aes_word_t rot_word;
	aes_word_t next_word;

	always_comb begin
		prev_word = sched[word_cnt - 6'd1];
		rot_word = {prev_word[23:0], prev_word[31:24]};
		if (word_cnt[1:0] == 2'b00) begin // RotWord, SubWord, Rcon
			next_word = sched[word_cnt - 6'd4] ^ {sbox(rot_word[31:24]) ^ rcon,
				sbox(rot_word[23:16]), sbox(rot_word[15:8]), sbox(rot_word[7:0])};
		end else begin
			next_word = sched[word_cnt - 6'd4] ^ prev_word;
		end
	end

	always_ff @(posedge clk) begin
		if (expand_start) begin
			for (int k = 0; k < `AES_KEY_WORDS; k++)
				sched[k] <= Cipherkey.cols[k];
		end else if (busy) begin
			sched[word_cnt] <= next_word;
		end
	end

	always_ff @(posedge clk, negedge Reset) begin
		if (!Reset) begin
			word_cnt <= '0;
			busy <= 1'b0;
			rcon <= 8'h01;
			key_ready <= 1'b0;
		end else if (expand_start) begin
			word_cnt <= 6'(`AES_KEY_WORDS);
			busy <= 1'b1;
			rcon <= 8'h01;
			key_ready <= 1'b0;
		end else if (busy) begin
			word_cnt <= word_cnt + 6'd1;
			if (word_cnt[1:0] == 2'b00)
				rcon <= gf_mul(rcon, 8'h02);
			if (word_cnt == 6'(`AES_SCHED_WORDS - 1)) begin // Last word written
				busy <= 1'b0;
				key_ready <= 1'b1;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < 4; k++)
			round_key.cols[k] = sched[{round_idx, 2'b00} + 6'(k)];
	end

endmodule

`default_nettype wire

// ==== verilog/inv_round_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module inv_round_datapath import inv_aes_pkg::*; (
	input logic clk,
	input logic Reset,
	input logic load,
	input logic step,
	input logic last_round,
	input aes_block_u Ciphertext,
	input aes_block_u round_key,
	output aes_block_u state
);

	aes_block_u shifted;
	aes_block_u subbed;
	aes_block_u added;
	aes_block_u mixed;

	// One column through the inverse mix matrix
	function automatic aes_word_t inv_mix_col(aes_word_t w);
		aes_byte_t coef [0:3];
		aes_byte_t a [0:3];
		aes_word_t o;
		coef[0] = 8'h0e;
		coef[1] = 8'h0b;
		coef[2] = 8'h0d;
		coef[3] = 8'h09;
		for (int j = 0; j < 4; j++)
			a[j] = w[31 - 8*j -: 8];
		o = '0;
		for (int r = 0; r < 4; r++) begin
			for (int j = 0; j < 4; j++)
				o[31 - 8*r -: 8] = o[31 - 8*r -: 8] ^ gf_mul(coef[(j - r + 4) % 4], a[j]);
		end
		return o;
	endfunction

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) // Row r rotates right by r
				shifted.bytes[r + 4*c] = state.bytes[r + 4*((c - r + 4) % 4)];
		end
		for (int i = 0; i < 16; i++)
			subbed.bytes[i] = inv_sbox(shifted.bytes[i]);
		for (int k = 0; k < 4; k++) begin
			added.cols[k] = subbed.cols[k] ^ round_key.cols[k];
			mixed.cols[k] = inv_mix_col(added.cols[k]);
		end
	end

	always_ff @(posedge clk, negedge Reset) begin
		if (!Reset) begin
			state <= '0;
		end else if (load) begin
			for (int k = 0; k < 4; k++)
				state.cols[k] <= Ciphertext.cols[k] ^ round_key.cols[k];
		end else if (step) begin
			state <= last_round ? added : mixed; // No mixing in the final round
		end
	end

endmodule

`default_nettype wire

// ==== verilog/inv_cipher_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "inv_aes_cfg.svh"

module inv_cipher_ctrl import inv_aes_pkg::*; (
	input logic clk,
	input logic Reset,
	input logic Run,
	input logic key_ready,
	output logic expand_start,
	output logic load,
	output logic step,
	output logic last_round,
	output logic [3:0] round_idx,
	output logic Ready
);

	ctrl_state_t state;
	ctrl_state_t next_state;
	logic [3:0] rnd;

	always_ff @(posedge clk, negedge Reset) begin
		if (!Reset) begin
			state <= WAIT;
			rnd <= '0;
		end else begin
			state <= next_state;
			if (state == EXPAND)
				rnd <= 4'(`AES_ROUNDS); // Key add uses the last round key
			else if (load || (step && !last_round))
				rnd <= rnd - 4'd1;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			WAIT: begin
				if (Run)
					next_state = EXPAND;
			end
			EXPAND: begin
				if (key_ready)
					next_state = KEY_ADD;
			end
			KEY_ADD: next_state = ROUND;
			ROUND: begin
				if (rnd == 4'd0)
					next_state = FINISH;
			end
			FINISH: begin
				if (!Run) // Hold result while Run stays high
					next_state = WAIT;
			end
			default: next_state = WAIT;
		endcase
	end

	assign expand_start = (state == WAIT) && Run;
	assign load = (state == KEY_ADD);
	assign step = (state == ROUND);
	assign last_round = step && (rnd == 4'd0);
	assign round_idx = rnd;
	assign Ready = (state == FINISH);

endmodule

`default_nettype wire

// ==== verilog/inv_aes.sv ====
`timescale 1ns/1ps
`default_nettype none

module inv_aes import inv_aes_pkg::*; (
	input logic clk,
	input logic Reset,
	input logic Run,
	input aes_block_u Ciphertext,
	input aes_block_u Cipherkey,
	output aes_block_u Plaintext,
	output logic Ready
);

	logic expand_start;
	logic key_ready;
	logic load;
	logic step;
	logic last_round;
	logic [3:0] round_idx;
	aes_block_u round_key;

	key_expansion u_key_expansion (
		.clk(clk),
		.Reset(Reset),
		.expand_start(expand_start),
		.Cipherkey(Cipherkey),
		.round_idx(round_idx),
		.round_key(round_key),
		.key_ready(key_ready)
	);

	inv_cipher_ctrl u_ctrl (
		.clk(clk),
		.Reset(Reset),
		.Run(Run),
		.key_ready(key_ready),
		.expand_start(expand_start),
		.load(load),
		.step(step),
		.last_round(last_round),
		.round_idx(round_idx),
		.Ready(Ready)
	);

	inv_round_datapath u_datapath (
		.clk(clk),
		.Reset(Reset),
		.load(load),
		.step(step),
		.last_round(last_round),
		.Ciphertext(Ciphertext),
		.round_key(round_key),
		.state(Plaintext)
	);

endmodule

`default_nettype wire

// ==== verification/inv_aes_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "inv_aes_cfg.svh"

module inv_aes_checker import inv_aes_pkg::*; (
	input logic clk,
	input logic Reset,
	input logic Run,
	input logic expand_start,
	input aes_block_u Plaintext,
	input logic Ready
);

	localparam int READY_EDGE = `AES_LATENCY + 1; // Sampled one tick after the rising edge

	int fail_count = 0;

	a_ready_low_in_reset: assert property (@(posedge clk) !Reset |-> !Ready)
		else begin
			$error("Ready high while reset is asserted");
			fail_count = fail_count + 1;
		end

	// Ready only ever follows a start
	a_ready_needs_start: assert property (@(posedge clk) disable iff (!Reset)
		$rose(Ready) |-> $past(expand_start, READY_EDGE))
		else begin
			$error("Ready rose without a start the expected number of edges before");
			fail_count = fail_count + 1;
		end

	a_latency: assert property (@(posedge clk) disable iff (!Reset)
		expand_start |-> ##READY_EDGE $rose(Ready))
		else begin
			$error("Ready did not rise at the expected latency");
			fail_count = fail_count + 1;
		end

	a_hold: assert property (@(posedge clk) disable iff (!Reset)
		Ready && Run |=> Ready && $stable(Plaintext))
		else begin
			$error("Result not held while Run stayed high");
			fail_count = fail_count + 1;
		end

	a_fall: assert property (@(posedge clk) disable iff (!Reset)
		Ready && !Run |=> !Ready)
		else begin
			$error("Ready did not fall after Run dropped");
			fail_count = fail_count + 1;
		end

endmodule

`default_nettype wire

// ==== verification/inv_aes_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "inv_aes_cfg.svh"

module inv_aes_monitor import inv_aes_pkg::*; (
	input logic clk,
	input logic Reset,
	input logic Run,
	input logic Ready,
	input aes_block_u Plaintext,
	input aes_block_u exp_plain,
	input logic [8*12-1:0] test_name,
	output int err_count,
	output int checked_count
);

	typedef enum logic [1:0] {
		MON_IDLE,
		MON_BUSY,
		MON_DONE,
		MON_FALL
	} mon_phase_t;

	mon_phase_t phase;
	int cnt;
	aes_block_u held;

	always @(posedge clk or negedge Reset) begin
		if (!Reset) begin
			phase <= MON_IDLE;
			cnt <= 0;
			held <= '0;
			err_count <= 0;
			checked_count <= 0;
		end else begin
			case (phase)
				MON_IDLE: begin
					if (Ready) begin
						$display("Ready was high with no decryption started");
						err_count <= err_count + 1;
					end else if (Run) begin
						phase <= MON_BUSY;
						cnt <= 0;
					end
				end
				MON_BUSY: begin
					if (Ready) begin // Rose on the previous edge
						checked_count <= checked_count + 1;
						if (cnt != `AES_LATENCY) begin
							$display("ERR %s latency expected %0d actual %0d",
								test_name, `AES_LATENCY, cnt);
							err_count <= err_count + 1;
						end
						if (Plaintext !== exp_plain) begin
							$display("ERR %s plaintext expected %h actual %h",
								test_name, exp_plain, Plaintext);
							err_count <= err_count + 1;
						end
						held <= Plaintext;
						phase <= Run ? MON_DONE : MON_FALL;
					end else if (cnt > `AES_LATENCY + 10) begin
						$display("Ready never rose in %s", test_name);
						err_count <= err_count + 1;
						phase <= MON_IDLE;
					end else begin
						cnt <= cnt + 1;
					end
				end
				MON_DONE: begin
					if (!Ready) begin
						$display("Ready fell while Run was still high in %s", test_name);
						err_count <= err_count + 1;
						phase <= MON_IDLE;
					end else begin
						if (Plaintext !== held) begin
							$display("ERR %s held plaintext expected %h actual %h",
								test_name, held, Plaintext);
							err_count <= err_count + 1;
						end
						if (!Run)
							phase <= MON_FALL;
					end
				end
				MON_FALL: begin
					if (Ready) begin
						$display("Ready did not fall one edge after Run dropped in %s",
							test_name);
						err_count <= err_count + 1;
						phase <= MON_IDLE;
					end else if (Run) begin // Back-to-back start from WAIT
						phase <= MON_BUSY;
						cnt <= 0;
					end else begin
						phase <= MON_IDLE;
					end
				end
				default: phase <= MON_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verification/inv_aes_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "inv_aes_cfg.svh"

module inv_aes_tb import inv_aes_pkg::*; ();

	localparam int NUM_TESTS = 4;
	localparam int HOLD_CYCLES = 3;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (`AES_LATENCY + 10) + 20;

	typedef struct packed {
		logic [8*12-1:0] name;
		aes_block_u key;
		aes_block_u ct;
		aes_block_u pt;
		logic glitch; // Drop Run for a while mid-run
	} test_vec_t;

	logic clk;
	logic Reset;
	logic run;
	aes_block_u ciphertext;
	aes_block_u cipherkey;
	aes_block_u plaintext;
	logic ready;

	aes_block_u exp_plain;
	logic [8*12-1:0] test_name;
	int mon_errors;
	int mon_checked;
	int chk_errors;
	int tb_errors;
	test_vec_t vectors [0:NUM_TESTS-1];

	inv_aes dut (
		.clk(clk),
		.Reset(Reset),
		.Run(run),
		.Ciphertext(ciphertext),
		.Cipherkey(cipherkey),
		.Plaintext(plaintext),
		.Ready(ready)
	);

	inv_aes_monitor u_monitor (
		.clk(clk),
		.Reset(Reset),
		.Run(run),
		.Ready(ready),
		.Plaintext(plaintext),
		.exp_plain(exp_plain),
		.test_name(test_name),
		.err_count(mon_errors),
		.checked_count(mon_checked)
	);

	bind inv_aes inv_aes_checker u_checker (
		.clk(clk),
		.Reset(Reset),
		.Run(Run),
		.expand_start(expand_start),
		.Plaintext(Plaintext),
		.Ready(Ready)
	);

	function automatic test_vec_t make_vec(input logic [8*12-1:0] name,
		input logic [127:0] key, input logic [127:0] ct, input logic [127:0] pt,
		input logic glitch);
		test_vec_t v;
		v.name = name;
		v.key = key;
		v.ct = ct;
		v.pt = pt;
		v.glitch = glitch;
		return v;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic decrypt_vector(input test_vec_t v);
		int wait_cycles;
		test_name = v.name;
		exp_plain = v.pt;
		cipherkey = v.key;
		ciphertext = v.ct;
		run = 1'b1;
		wait_cycles = 0;
		next_cycle(); // Start edge
		while (!ready && wait_cycles < `AES_LATENCY + 10) begin
			if (v.glitch && wait_cycles == 10)
				run = 1'b0;
			if (v.glitch && wait_cycles == 12)
				run = 1'b1;
			next_cycle();
			wait_cycles++;
		end
		if (!ready) begin
			$display("Ready never came up for %s", v.name);
			tb_errors++;
		end
		repeat (HOLD_CYCLES)
			next_cycle();
		run = 1'b0;
		next_cycle(); // Ready falls here
		next_cycle();
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		Reset = 1'b0;
		run = 1'b0;
		ciphertext = '0;
		cipherkey = '0;
		exp_plain = '0;
		test_name = "reset";
		tb_errors = 0;
		chk_errors = 0;

		// FIPS-197 known answers where neighbours never share a key
		vectors[0] = make_vec("fips_c1", 128'h000102030405060708090a0b0c0d0e0f,
			128'h69c4e0d86a7b0430d8cdb78070b4c55a, 128'h00112233445566778899aabbccddeeff,
			1'b0);
		vectors[1] = make_vec("fips_b", 128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h3925841d02dc09fbdc118597196a0b32, 128'h3243f6a8885a308d313198a2e0370734,
			1'b1);
		vectors[2] = make_vec("zero_key", 128'h0,
			128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 128'h0, 1'b0);
		vectors[3] = make_vec("c1_run_glch", 128'h000102030405060708090a0b0c0d0e0f,
			128'h69c4e0d86a7b0430d8cdb78070b4c55a, 128'h00112233445566778899aabbccddeeff,
			1'b1);

		repeat (8) @(posedge clk);
		#1;
		Reset = 1'b1;
		next_cycle(); // Idle so Ready must stay low
		next_cycle();
		if (ready) begin
			$display("Ready high after reset before any Run");
			tb_errors++;
		end

		for (int i = 0; i < NUM_TESTS; i++)
			decrypt_vector(vectors[i]);

		if (mon_checked != NUM_TESTS) begin
			$display("Only %0d of %0d results were seen by the monitor", mon_checked,
				NUM_TESTS);
			tb_errors++;
		end

		chk_errors = dut.u_checker.fail_count;
		$display("Errors: %0d total (monitor %0d, checker %0d, testbench %0d)",
			mon_errors + chk_errors + tb_errors, mon_errors, chk_errors, tb_errors);
		if (mon_errors == 0 && chk_errors == 0 && tb_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== inv_aes.f ====
+incdir+include
verilog/inv_aes_pkg.sv
verilog/key_expansion.sv
verilog/inv_round_datapath.sv
verilog/inv_cipher_ctrl.sv
verilog/inv_aes.sv
verification/inv_aes_checker.sv
verification/inv_aes_monitor.sv
verification/inv_aes_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST ?= inv_aes.f
TOP ?= inv_aes_tb
RTL_TOP ?= inv_aes
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
